/* hw/alu_arith.sv */
// ######################################################################
// add and subtract with carry, nibble chained for half carry
// ######################################################################

module alu_arith import alu_pkg::*; (
    input  alu_op_t op_sel,
    input  width_t  w,
    input  data_t   op_a,
    input  data_t   op_b,
    input  logic    carry,
    output data_t   sum,
    output flags_t  arith_flags
);

    logic  sub_op;
    logic  use_c;
    logic  cin;
    data_t b_eff;
    logic  c4;
    logic  c8;
    logic  c16;
    logic  c32;
    logic  wc;
    logic  sa;
    logic  sb;
    logic  sr;

    assign sub_op = op_sel inside {ALU_SUB, ALU_SBC, ALU_CP};
    assign use_c  = op_sel inside {ALU_ADC, ALU_SBC};

    // a - b - borrow done as a + ~b + ~borrow
    assign b_eff = sub_op ? ~op_b : op_b;
    assign cin   = (use_c & carry) ^ sub_op;

    assign {c4, sum[3:0]}    = {1'b0, op_a[3:0]} + {1'b0, b_eff[3:0]} + {4'd0, cin};
    assign {c8, sum[7:4]}    = {1'b0, op_a[7:4]} + {1'b0, b_eff[7:4]} + {4'd0, c4};
    assign {c16, sum[15:8]}  = {1'b0, op_a[15:8]} + {1'b0, b_eff[15:8]} + {8'd0, c8};
    assign {c32, sum[31:16]} = {1'b0, op_a[31:16]} + {1'b0, b_eff[31:16]} + {16'd0, c16};

    assign wc = w[W_LONG] ? c32 :
                w[W_WORD] ? c16 : c8;

    // overflow when both inputs agree in sign and the result does not
    assign sa = width_sign(w, op_a);
    assign sb = width_sign(w, b_eff);
    assign sr = width_sign(w, sum);

    always_comb begin
        arith_flags         = '0;
        arith_flags[FLAG_S] = sr;
        arith_flags[FLAG_Z] = width_zero(w, sum);
        arith_flags[FLAG_H] = c4 ^ sub_op;   // borrow out of bit 3 on subtract
        arith_flags[FLAG_V] = (sa == sb) && (sr != sa);
        arith_flags[FLAG_N] = sub_op;
        arith_flags[FLAG_C] = wc ^ sub_op;
    end

endmodule

/* hw/alu_flag_reg.sv */
// ######################################################################
// result mux, dout and flag registers, shadow flags, write strobe
// ######################################################################

module alu_flag_reg import alu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  alu_op_t op_sel,
    input  width_t  w,
    input  logic    busy,
    input  data_t   sum,
    input  flags_t  arith_flags,
    input  data_t   logic_out,
    input  flags_t  logic_flags,
    input  logic    bit_z,
    input  logic    done,
    input  width_t  sh_w,
    input  data_t   sh_out,
    input  logic    sh_c,
    output data_t   dout,
    output flags_t  flags,
    output logic    carry,
    output logic    start,
    output width_t  alu_we
);

    flags_t f;
    flag6_t shadow;
    data_t  dout_nx;
    flags_t f_nx;
    flag6_t shadow_nx;
    logic   is_shift;
    logic   issue;

    assign is_shift = op_sel inside {ALU_RLC, ALU_RRC, ALU_RL, ALU_RR,
                                     ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL};
    assign start = (w != '0) && !busy && is_shift;
    assign issue = (w != '0) && !busy && !is_shift;   // single-cycle ops

    assign flags = f;
    assign carry = f[FLAG_C];

    always_comb begin
        dout_nx   = dout;
        f_nx      = f;
        shadow_nx = shadow;
        if (done) begin
            dout_nx      = sh_out;
            f_nx         = '0;   // H and N cleared
            f_nx[FLAG_S] = width_sign(sh_w, sh_out);
            f_nx[FLAG_Z] = width_zero(sh_w, sh_out);
            f_nx[FLAG_V] = width_even(sh_w, sh_out);
            f_nx[FLAG_C] = sh_c;
        end else if (issue) begin
            case (op_sel)
                ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP: begin
                    dout_nx = sum;
                    f_nx    = arith_flags;
                end
                ALU_AND, ALU_OR, ALU_XOR: begin
                    dout_nx = logic_out;
                    f_nx    = logic_flags;
                end
                ALU_SET, ALU_RES, ALU_CHG: begin
                    dout_nx = logic_out;
                end
                ALU_BIT: begin
                    f_nx[FLAG_Z] = bit_z;
                    f_nx[FLAG_H] = 1'b1;
                    f_nx[FLAG_N] = 1'b0;
                end
                ALU_SCF, ALU_RCF: begin
                    f_nx[FLAG_C] = op_sel == ALU_SCF;
                    f_nx[FLAG_H] = 1'b0;
                    f_nx[FLAG_N] = 1'b0;
                end
                ALU_CCF: begin
                    f_nx[FLAG_C] = ~f[FLAG_C];
                    f_nx[FLAG_N] = 1'b0;
                end
                ALU_ZCF: begin
                    f_nx[FLAG_C] = ~f[FLAG_Z];
                    f_nx[FLAG_N] = 1'b0;
                end
                ALU_EXFF: begin
                    shadow_nx = {f[FLAG_S], f[FLAG_Z], f[FLAG_H],
                                 f[FLAG_V], f[FLAG_N], f[FLAG_C]};
                    f_nx      = '0;
                    {f_nx[FLAG_S], f_nx[FLAG_Z], f_nx[FLAG_H],
                     f_nx[FLAG_V], f_nx[FLAG_N], f_nx[FLAG_C]} = shadow;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout   <= '0;
            f      <= '0;
            shadow <= '0;
            alu_we <= '0;
        end else begin
            dout   <= dout_nx;
            f      <= f_nx;
            shadow <= shadow_nx;
            alu_we <= issue ? w : done ? sh_w : '0;   // one pulse per op
        end
    end

    a_flag_gaps: assert property (@(posedge clk) disable iff (rst) !flags[5] && !flags[3])
        else $error("unused flag bit set");
    a_w_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(w))
        else $error("width code not one-hot");

endmodule

/* hw/alu_logic.sv */
// ######################################################################
// logic operations and register bit operations
// ######################################################################

module alu_logic import alu_pkg::*; (
    input  alu_op_t op_sel,
    input  width_t  w,
    input  data_t   op_a,
    input  data_t   op_b,
    output data_t   logic_out,
    output flags_t  logic_flags,
    output logic    bit_z
);

    data_t bit_mask;

    // only bits 0 to 15 can be addressed
    assign bit_mask = data_t'(1) << op_b[3:0];
    assign bit_z    = ~|(op_a & bit_mask);

    always_comb begin
        case (op_sel)
            ALU_AND: begin
                logic_out = op_a & op_b;
            end
            ALU_OR: begin
                logic_out = op_a | op_b;
            end
            ALU_XOR: begin
                logic_out = op_a ^ op_b;
            end
            ALU_SET: begin
                logic_out = op_a | bit_mask;
            end
            ALU_RES: begin
                logic_out = op_a & ~bit_mask;
            end
            ALU_CHG: begin
                logic_out = op_a ^ bit_mask;
            end
            default: begin
                logic_out = op_a;
            end
        endcase
    end

    // flags for AND, OR and XOR
    always_comb begin
        logic_flags         = '0;
        logic_flags[FLAG_S] = width_sign(w, logic_out);
        logic_flags[FLAG_Z] = width_zero(w, logic_out);
        logic_flags[FLAG_H] = op_sel == ALU_AND;
        logic_flags[FLAG_V] = width_even(w, logic_out);   // parity in V
    end

endmodule

/* hw/alu_pkg.sv */
// ######################################################################
// alu package: widths, vector types, op and state enums, flag
// bit positions and width helper functions
// ######################################################################

package alu_pkg;

    localparam int DATA_W  = 32;
    localparam int WIDTH_W = 3;
    localparam int FLAGS_W = 8;
    localparam int FLAG6_W = 6;
    localparam int SHCNT_W = 5;
    localparam int OP_W    = 6;

    // index into the one-hot width code
    localparam int W_BYTE = 0;
    localparam int W_WORD = 1;
    localparam int W_LONG = 2;

    // flag byte is S Z 0 H 0 V N C
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [WIDTH_W-1:0] width_t;
    typedef logic [FLAGS_W-1:0] flags_t;
    typedef logic [FLAG6_W-1:0] flag6_t;   // S Z H V N C
    typedef logic [SHCNT_W-1:0] shcnt_t;   // 1 to 16

    typedef enum logic [OP_W-1:0] {
        ALU_ADD  = 6'd0,
        ALU_ADC  = 6'd1,
        ALU_SUB  = 6'd2,
        ALU_SBC  = 6'd3,
        ALU_CP   = 6'd4,
        ALU_AND  = 6'd5,
        ALU_OR   = 6'd6,
        ALU_XOR  = 6'd7,
        ALU_BIT  = 6'd8,
        ALU_SET  = 6'd9,
        ALU_RES  = 6'd10,
        ALU_CHG  = 6'd11,
        ALU_SCF  = 6'd12,
        ALU_RCF  = 6'd13,
        ALU_CCF  = 6'd14,
        ALU_ZCF  = 6'd15,
        ALU_EXFF = 6'd16,
        ALU_RLC  = 6'd17,
        ALU_RRC  = 6'd18,
        ALU_RL   = 6'd19,
        ALU_RR   = 6'd20,
        ALU_SLA  = 6'd21,
        ALU_SRA  = 6'd22,
        ALU_SLL  = 6'd23,
        ALU_SRL  = 6'd24
    } alu_op_t;

    typedef enum logic {
        SH_IDLE,
        SH_RUN
    } shift_state_t;

    // top bit at the current width
    function automatic logic width_sign(width_t w, data_t d);
        if (w[W_BYTE])
            return d[7];
        else if (w[W_WORD])
            return d[15];
        return d[31];
    endfunction

    function automatic logic width_zero(width_t w, data_t d);
        if (w[W_BYTE])
            return d[7:0] == 8'd0;
        else if (w[W_WORD])
            return d[15:0] == 16'd0;
        return d == '0;
    endfunction

    // even parity, never wider than 16 bits
    function automatic logic width_even(width_t w, data_t d);
        if (w[W_BYTE])
            return ~^d[7:0];
        return ~^d[15:0];
    endfunction

endpackage

/* hw/alu_shifter.sv */
// ######################################################################
// multi-cycle shift and rotate engine, one bit per clock
// ######################################################################

module alu_shifter import alu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  alu_op_t op_sel,
    input  width_t  w,
    input  data_t   op_a,
    input  data_t   op_b,
    input  logic    carry,
    output logic    busy,
    output logic    done,
    output width_t  sh_w,
    output data_t   sh_out,
    output logic    sh_c
);

    shift_state_t state;
    shcnt_t       cnt;       // steps still to go while running
    shcnt_t       n_steps;
    data_t        work;
    logic         work_c;
    alu_op_t      cap_op;
    width_t       cap_w;

    alu_op_t      cur_op;
    width_t       cur_w;
    data_t        cur;
    logic         cur_c;
    logic         top;
    logic         left;
    logic         feed;
    data_t        step;
    logic         step_c;

    assign busy    = state == SH_RUN;
    assign n_steps = {op_b[3:0] == 4'd0, op_b[3:0]};   // 0 means 16

    // the issue cycle steps straight from the inputs
    assign cur_op = busy ? cap_op : op_sel;
    assign cur_w  = busy ? cap_w : w;
    assign cur    = busy ? work : op_a;
    assign cur_c  = busy ? work_c : carry;

    assign top  = width_sign(cur_w, cur);
    assign left = cur_op inside {ALU_RLC, ALU_RL, ALU_SLA, ALU_SLL};

    always_comb begin
        case (cur_op)
            ALU_RLC:        feed = top;
            ALU_RRC:        feed = cur[0];
            ALU_RL, ALU_RR: feed = cur_c;
            ALU_SRA:        feed = top;     // sign copy
            default:        feed = 1'b0;
        endcase
    end

    always_comb begin
        step = cur;   // bits above the width stay as they were
        if (cur_w[W_BYTE]) begin
            step[7:0] = left ? {cur[6:0], feed} : {feed, cur[7:1]};
        end else if (cur_w[W_WORD]) begin
            step[15:0] = left ? {cur[14:0], feed} : {feed, cur[15:1]};
        end else begin
            step = left ? {cur[30:0], feed} : {feed, cur[31:1]};
        end
    end

    assign step_c = left ? top : cur[0];   // bit that leaves

    assign done   = (start && n_steps == 5'd1) || (busy && cnt == 5'd1);
    assign sh_w   = cur_w;
    assign sh_out = step;
    assign sh_c   = step_c;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SH_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                SH_IDLE: begin
                    if (start && n_steps != 5'd1) begin
                        state <= SH_RUN;
                        cnt   <= n_steps - 5'd1;
                    end
                end
                SH_RUN: begin
                    cnt <= cnt - 5'd1;
                    if (cnt == 5'd1)
                        state <= SH_IDLE;
                end
                default: state <= SH_IDLE;
            endcase
        end
    end

    // working copy of the operand and running carry
    always_ff @(posedge clk) begin
        if (start) begin
            cap_op <= op_sel;
            cap_w  <= w;
        end
        if (start || busy) begin
            work   <= step;
            work_c <= step_c;
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        busy |-> (cnt != 5'd0 && cnt < 5'd16))
        else $error("shift step count out of range");

endmodule

/* hw/alu_top.sv */
// ######################################################################
// alu top level, connects datapath, shifter and state registers
// ######################################################################

module alu_top import alu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  alu_op_t op_sel,
    input  width_t  w,
    input  data_t   op_a,
    input  data_t   op_b,
    output data_t   dout,
    output flags_t  flags,
    output logic    busy,
    output width_t  alu_we
);

    data_t  sum;
    flags_t arith_flags;
    data_t  logic_out;
    flags_t logic_flags;
    logic   bit_z;
    logic   carry;
    logic   start;
    logic   done;
    width_t sh_w;
    data_t  sh_out;
    logic   sh_c;

    alu_arith u_arith (
        .op_sel     (op_sel),
        .w          (w),
        .op_a       (op_a),
        .op_b       (op_b),
        .carry      (carry),
        .sum        (sum),
        .arith_flags(arith_flags)
    );

    alu_logic u_logic (
        .op_sel     (op_sel),
        .w          (w),
        .op_a       (op_a),
        .op_b       (op_b),
        .logic_out  (logic_out),
        .logic_flags(logic_flags),
        .bit_z      (bit_z)
    );

    alu_shifter u_shifter (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .op_sel(op_sel),
        .w     (w),
        .op_a  (op_a),
        .op_b  (op_b),
        .carry (carry),
        .busy  (busy),
        .done  (done),
        .sh_w  (sh_w),
        .sh_out(sh_out),
        .sh_c  (sh_c)
    );

    alu_flag_reg u_flag_reg (
        .clk        (clk),
        .rst        (rst),
        .op_sel     (op_sel),
        .w          (w),
        .busy       (busy),
        .sum        (sum),
        .arith_flags(arith_flags),
        .logic_out  (logic_out),
        .logic_flags(logic_flags),
        .bit_z      (bit_z),
        .done       (done),
        .sh_w       (sh_w),
        .sh_out     (sh_out),
        .sh_c       (sh_c),
        .dout       (dout),
        .flags      (flags),
        .carry      (carry),
        .start      (start),
        .alu_we     (alu_we)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the alu testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --top-module alu_tb \
    -f verilog.f --Mdir "$BUILD_DIR" -o alu_sim
if [ $? -ne 0 ]; then
    echo "ERROR: Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/alu_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "ERROR: simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG_FILE"; then
    echo "PASS"
    exit 0
else
    echo "FAIL: pass message not found in $LOG_FILE"
    exit 1
fi

/* testbench/alu_tb.sv */
// ######################################################################
// alu testbench: random stimulus, reference model, compare tasks
// and watchdog
// ######################################################################

module alu_tb import alu_pkg::*; ();

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int DRIVE_DLY     = 1;
    localparam int N_ARITH       = 300;
    localparam int N_LOGIC       = 300;
    localparam int N_MIX         = 200;
    localparam int N_SHIFT       = 200;
    localparam int N_DIRECT      = 3;
    localparam int TOTAL_OPS     = N_ARITH + N_LOGIC + N_MIX + N_SHIFT + N_SHIFT / 4 + N_DIRECT;
    localparam int WATCHDOG_TIME = TOTAL_OPS * 18 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic    clk;
    logic    rst;
    alu_op_t op_sel;
    width_t  w;
    data_t   op_a;
    data_t   op_b;
    data_t   dout;
    flags_t  flags;
    logic    busy;
    width_t  alu_we;

    int      seed = 87;
    data_t   m_dout;     // model state
    flags_t  m_flags;
    flag6_t  m_shadow;

    tb_clk_gen clk_gen_i (.clk(clk));

    alu_top dut_i (
        .clk   (clk),
        .rst   (rst),
        .op_sel(op_sel),
        .w     (w),
        .op_a  (op_a),
        .op_b  (op_b),
        .dout  (dout),
        .flags (flags),
        .busy  (busy),
        .alu_we(alu_we)
    );

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_data(string name, data_t exp, data_t act);
        if (act !== exp)
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_flags(string name, flags_t exp, flags_t act);
        if (act !== exp)
            abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_we(string name, width_t exp, width_t act);
        if (act !== exp)
            abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_busy(string name, logic exp, logic act);
        if (act !== exp)
            abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    endtask

    function automatic int width_bits(width_t wv);
        if (wv[W_BYTE])
            return 8;
        if (wv[W_WORD])
            return 16;
        return 32;
    endfunction

    function automatic data_t width_mask(width_t wv);
        if (wv[W_BYTE])
            return 32'h0000_00ff;
        if (wv[W_WORD])
            return 32'h0000_ffff;
        return 32'hffff_ffff;
    endfunction

    function automatic logic sign_at(width_t wv, data_t d);
        return d[width_bits(wv) - 1];
    endfunction

    function automatic logic zero_at(width_t wv, data_t d);
        return (d & width_mask(wv)) == 32'd0;
    endfunction

    // parity never looks past bit 15
    function automatic logic even_parity(width_t wv, data_t d);
        return ~^(d & (wv[W_BYTE] ? 32'h0000_00ff : 32'h0000_ffff));
    endfunction

    function automatic width_t random_width();
        return width_t'(3'b001 << ($unsigned($random(seed)) % 3));
    endfunction

    // ops of one group sit next to each other in the enum
    function automatic alu_op_t random_op(alu_op_t first, alu_op_t last);
        int span;
        span = int'(last) - int'(first) + 1;
        return alu_op_t'(OP_W'(int'(first) + int'($unsigned($random(seed)) % span)));
    endfunction

    task automatic apply_arith(alu_op_t op, width_t wv, data_t a, data_t b);
        logic        sub;
        logic        cy;
        logic [4:0]  nib;
        logic [32:0] wide;
        data_t       r;
        logic        sa;
        logic        sb;
        logic        sr;
        sub = op inside {ALU_SUB, ALU_SBC, ALU_CP};
        cy  = (op inside {ALU_ADC, ALU_SBC}) ? m_flags[FLAG_C] : 1'b0;
        if (sub) begin
            r    = a - b - {31'd0, cy};
            nib  = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cy};
            wide = {1'b0, a & width_mask(wv)} - {1'b0, b & width_mask(wv)} - {32'd0, cy};
        end else begin
            r    = a + b + {31'd0, cy};
            nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cy};
            wide = {1'b0, a & width_mask(wv)} + {1'b0, b & width_mask(wv)} + {32'd0, cy};
        end
        sa = sign_at(wv, a);
        sb = sign_at(wv, b);
        sr = sign_at(wv, r);
        m_dout          = r;   // CP writes its difference too
        m_flags         = '0;
        m_flags[FLAG_S] = sr;
        m_flags[FLAG_Z] = zero_at(wv, r);
        m_flags[FLAG_H] = nib[4];
        m_flags[FLAG_V] = sub ? (sa != sb && sr != sa) : (sa == sb && sr != sa);
        m_flags[FLAG_N] = sub;
        m_flags[FLAG_C] = wide[width_bits(wv)];
    endtask

    task automatic apply_logic(alu_op_t op, width_t wv, data_t a, data_t b);
        data_t r;
        data_t bm;
        bm = 32'h1 << b[3:0];
        case (op)
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            ALU_SET: r = a | bm;
            ALU_RES: r = a & ~bm;
            ALU_CHG: r = a ^ bm;
            default: r = m_dout;   // BIT
        endcase
        m_dout = r;
        if (op == ALU_BIT) begin
            m_flags[FLAG_Z] = ~a[b[3:0]];
            m_flags[FLAG_H] = 1'b1;
            m_flags[FLAG_N] = 1'b0;
        end else if (op inside {ALU_AND, ALU_OR, ALU_XOR}) begin
            m_flags         = '0;
            m_flags[FLAG_S] = sign_at(wv, r);
            m_flags[FLAG_Z] = zero_at(wv, r);
            m_flags[FLAG_H] = op == ALU_AND;
            m_flags[FLAG_V] = even_parity(wv, r);
        end
    endtask

    task automatic apply_flag_op(alu_op_t op);
        flags_t old;
        old = m_flags;
        case (op)
            ALU_SCF, ALU_RCF: begin
                m_flags[FLAG_C] = op == ALU_SCF;
                m_flags[FLAG_H] = 1'b0;
                m_flags[FLAG_N] = 1'b0;
            end
            ALU_CCF: begin
                m_flags[FLAG_C] = ~old[FLAG_C];
                m_flags[FLAG_N] = 1'b0;
            end
            ALU_ZCF: begin
                m_flags[FLAG_C] = ~old[FLAG_Z];
                m_flags[FLAG_N] = 1'b0;
            end
            ALU_EXFF: begin
                m_flags         = '0;
                m_flags[FLAG_S] = m_shadow[5];
                m_flags[FLAG_Z] = m_shadow[4];
                m_flags[FLAG_H] = m_shadow[3];
                m_flags[FLAG_V] = m_shadow[2];
                m_flags[FLAG_N] = m_shadow[1];
                m_flags[FLAG_C] = m_shadow[0];
                m_shadow = {old[FLAG_S], old[FLAG_Z], old[FLAG_H],
                            old[FLAG_V], old[FLAG_N], old[FLAG_C]};
            end
            default: ;
        endcase
    endtask

    // bit by bit, bits above the width untouched
    task automatic apply_shift(alu_op_t op, width_t wv, data_t a, int n);
        data_t cur;
        data_t nxt;
        logic  c;
        logic  top;
        logic  feed;
        logic  left;
        int    nb;
        nb   = width_bits(wv);
        cur  = a;
        c    = m_flags[FLAG_C];
        left = op inside {ALU_RLC, ALU_RL, ALU_SLA, ALU_SLL};
        for (int s = 0; s < n; s++) begin
            top = cur[nb - 1];
            case (op)
                ALU_RLC, ALU_SRA: feed = top;
                ALU_RRC:          feed = cur[0];
                ALU_RL, ALU_RR:   feed = c;
                default:          feed = 1'b0;
            endcase
            nxt = cur;
            for (int i = 0; i < nb; i++) begin
                if (left && i == 0)
                    nxt[i] = feed;
                else if (left)
                    nxt[i] = cur[i - 1];
                else if (i == nb - 1)
                    nxt[i] = feed;
                else
                    nxt[i] = cur[i + 1];
            end
            c   = left ? top : cur[0];
            cur = nxt;
        end
        m_dout          = cur;
        m_flags         = '0;
        m_flags[FLAG_S] = sign_at(wv, cur);
        m_flags[FLAG_Z] = zero_at(wv, cur);
        m_flags[FLAG_V] = even_parity(wv, cur);
        m_flags[FLAG_C] = c;
    endtask

    task automatic drive_junk();
        op_sel = random_op(ALU_ADD, ALU_SRL);
        w      = random_width();
        op_a   = $random(seed);
        op_b   = $random(seed);
    endtask

    task automatic run_single(alu_op_t op, width_t wv, data_t a, data_t b);
        string name;
        name = op.name();
        @(posedge clk);
        #DRIVE_DLY;
        check_busy({name, " idle busy"}, 1'b0, busy);
        check_we({name, " idle we"}, '0, alu_we);
        op_sel = op;
        w      = wv;
        op_a   = a;
        op_b   = b;
        if (op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP})
            apply_arith(op, wv, a, b);
        else if (op inside {ALU_SCF, ALU_RCF, ALU_CCF, ALU_ZCF, ALU_EXFF})
            apply_flag_op(op);
        else
            apply_logic(op, wv, a, b);
        @(posedge clk);   // issue edge
        #DRIVE_DLY;
        w = '0;
        check_data({name, " dout"}, m_dout, dout);
        check_flags({name, " flags"}, m_flags, flags);
        check_we({name, " we"}, wv, alu_we);
    endtask

    task automatic run_shift(alu_op_t op, width_t wv, data_t a, data_t b);
        string  name;
        int     n;
        data_t  hold_d;
        flags_t hold_f;
        name = op.name();
        n    = (b[3:0] == 4'd0) ? 16 : int'(b[3:0]);
        @(posedge clk);
        #DRIVE_DLY;
        check_busy({name, " idle busy"}, 1'b0, busy);
        check_we({name, " idle we"}, '0, alu_we);
        hold_d = m_dout;
        hold_f = m_flags;
        op_sel = op;
        w      = wv;
        op_a   = a;
        op_b   = b;
        apply_shift(op, wv, a, n);
        @(posedge clk);   // issue edge moves the first bit
        #DRIVE_DLY;
        for (int k = 2; k <= n; k++) begin
            check_busy({name, " busy"}, 1'b1, busy);
            check_we({name, " we while busy"}, '0, alu_we);
            check_data({name, " dout while busy"}, hold_d, dout);
            check_flags({name, " flags while busy"}, hold_f, flags);
            drive_junk();   // must be ignored
            @(posedge clk);
            #DRIVE_DLY;
        end
        w = '0;
        check_busy({name, " busy after last step"}, 1'b0, busy);
        check_data({name, " dout"}, m_dout, dout);
        check_flags({name, " flags"}, m_flags, flags);
        check_we({name, " we"}, wv, alu_we);
    endtask

    initial begin
        data_t  a;
        data_t  b;
        flags_t saved;
        rst      = 1'b1;
        op_sel   = ALU_ADD;
        w        = '0;
        op_a     = '0;
        op_b     = '0;
        m_dout   = '0;
        m_flags  = '0;
        m_shadow = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        check_data("reset dout", '0, dout);
        check_flags("reset flags", '0, flags);
        check_busy("reset busy", 1'b0, busy);
        check_we("reset we", '0, alu_we);

        for (int i = 0; i < N_ARITH; i++) begin
            a = $random(seed);
            b = (i % 8 == 0) ? a : $random(seed);   // zero results now and then
            run_single(random_op(ALU_ADD, ALU_CP), random_width(), a, b);
        end

        for (int i = 0; i < N_LOGIC; i++) begin
            a = $random(seed);
            b = $random(seed);
            run_single(random_op(ALU_AND, ALU_CHG), random_width(), a, b);
        end

        // carry ops and EXFF mixed with flag producers
        for (int i = 0; i < N_MIX; i++) begin
            a = $random(seed);
            b = $random(seed);
            run_single(random_op(ALU_ADD, ALU_EXFF), random_width(), a, b);
        end

        run_single(ALU_SUB, 3'b001, 32'h0000_0012, 32'h0000_0034);
        saved = m_flags;
        run_single(ALU_EXFF, 3'b010, '0, '0);
        run_single(ALU_EXFF, 3'b100, '0, '0);
        check_flags("EXFF pair restores flags", saved, flags);

        for (int i = 0; i < N_SHIFT; i++) begin
            a = $random(seed);
            b = $random(seed);
            if (i % 10 == 0)
                b[3:0] = 4'd0;   // count of 16
            else if (i % 10 == 1)
                b[3:0] = 4'd1;
            if (i % 4 == 0)
                run_single(random_op(ALU_ADD, ALU_CP), random_width(), b, a);
            run_shift(random_op(ALU_RLC, ALU_SRL), random_width(), a, b);
        end

        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        abort_run("run timed out before all operations finished");
    end

endmodule

/* testbench/tb_clk_gen.sv */
// ######################################################################
// testbench clock source, period of 20 time units
// ######################################################################

module tb_clk_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

/* verilog.f */
hw/alu_pkg.sv
hw/alu_arith.sv
hw/alu_logic.sv
hw/alu_shifter.sv
hw/alu_flag_reg.sv
hw/alu_top.sv
testbench/tb_clk_gen.sv
testbench/alu_tb.sv
